/* hdl/fpAdd_defines.svh */
`ifndef FP_ADD_DEFINES_SVH
`define FP_ADD_DEFINES_SVH

// Half precision word layout
`define FP_WIDTH 16
`define FP_EXP_W 5  // Biased exponent bits
`define FP_MAN_W 10 // Stored fraction bits
`define FP_BIAS 15

// Mantissa path word, top down:
// carry, hidden, fraction, 4 guard/round bits, sticky
`define FP_PATH_W 17

// Input fifo depth, also the sender's starting credits
`define IN_DEPTH 4
`define OUT_DEPTH 4 // Result buffer slots

`define TAG_W 8 // Request tag, returned with the result

`endif

/* hdl/fpFormatPkg.sv */
`default_nettype none

`include "fpAdd_defines.svh"

package fpFormatPkg;

	// IEEE binary16 fields
	typedef struct packed {
		logic                  sign;
		logic [`FP_EXP_W-1:0]  exponent; // Biased
		logic [`FP_MAN_W-1:0]  fraction;
	} fpHalf;

	// Carry | hidden | fraction | grs | sticky
	typedef logic [`FP_PATH_W-1:0] manPath;

	// Forced results that bypass the computed value
	typedef enum logic [1:0] {
		specNone,
		specNan,
		specInf,
		specZero
	} specialKind;

	// Word handed from stage to stage
	typedef struct packed {
		logic                        sign;
		logic signed [`FP_EXP_W+1:0] exponent;    // Biased, room for over/underflow
		manPath                      mantissa;
		specialKind                  special;
		logic                        specialSign; // Sign of a forced inf or zero
		logic [`TAG_W-1:0]           tag;
	} stageWord;

endpackage

`default_nettype wire

/* hdl/streamPkg.sv */
`default_nettype none

`include "fpAdd_defines.svh"

package streamPkg;

	typedef enum logic {
		opAdd,
		opSub
	} fpOp;

	// One request on the input channel
	typedef struct packed {
		fpFormatPkg::fpHalf a;
		fpFormatPkg::fpHalf b;
		fpOp                op; // a + b or a - b
		logic [`TAG_W-1:0]  tag;
	} opPair;

	// One beat on the output channel
	typedef struct packed {
		fpFormatPkg::fpHalf value;
		logic [`TAG_W-1:0]  tag; // Copied from the request
	} fpResult;

endpackage

`default_nettype wire

/* hdl/creditFifo.sv */
`timescale 1ns/1ps
`default_nettype none

// Circular buffer with the head always on popData
module creditFifo #(
	parameter type payloadType = logic,
	parameter int  DEPTH       = 4
) (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           push,
	input  payloadType                     pushData,
	input  logic                           pop,
	output payloadType                     popData,
	output logic                           empty,
	output logic [$clog2(DEPTH+1)-1:0]     freeCount
);

	localparam int ptrW   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int countW = $clog2(DEPTH + 1);

	payloadType             store [DEPTH]; // Payload storage
	logic [ptrW-1:0]        rdPtr;
	logic [ptrW-1:0]        wrPtr;
	logic [countW-1:0]      count;         // Entries held

	always_ff @(posedge clk) begin
		if (push) begin
			store[wrPtr] <= pushData;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == ptrW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1; // Wrap
			end
			if (pop) begin
				rdPtr <= (rdPtr == ptrW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	assign popData   = store[rdPtr];
	assign empty     = (count == '0);
	assign freeCount = countW'(DEPTH) - count; // Caller never pushes when zero

endmodule

`default_nettype wire

/* hdl/normalizeShift.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpAdd_defines.svh"

// Left shift of the mantissa path by 0..15, zeros in at the bottom
module normalizeShift (
	input  fpFormatPkg::manPath mantissaIn,
	input  logic [3:0]          shift,
	output fpFormatPkg::manPath mantissaOut
);

	localparam int pathW = `FP_PATH_W;

	fpFormatPkg::manPath level1; // After the coarse shift
	fpFormatPkg::manPath level2;

	// Coarse step, multiples of four
	always_comb begin
		case (shift[3:2])
			2'b00:   level1 = mantissaIn;
			2'b01:   level1 = {mantissaIn[pathW-5:0], 4'b0};
			2'b10:   level1 = {mantissaIn[pathW-9:0], 8'b0};
			default: level1 = {mantissaIn[pathW-13:0], 12'b0};
		endcase
	end

	// Fine step, 0 to 3
	always_comb begin
		case (shift[1:0])
			2'b00:   level2 = level1;
			2'b01:   level2 = {level1[pathW-2:0], 1'b0};
			2'b10:   level2 = {level1[pathW-3:0], 2'b0};
			default: level2 = {level1[pathW-4:0], 3'b0};
		endcase
	end

	assign mantissaOut = level2;

endmodule

`default_nettype wire

/* hdl/fpAlign.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpAdd_defines.svh"

// Stage 1 unpacks, orders by magnitude, aligns and adds or subtracts
module fpAlign (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  inValid,
	input  streamPkg::opPair      operands,
	output logic                  outValid,
	output fpFormatPkg::stageWord stage
);

	localparam int pathW = `FP_PATH_W;
	localparam int lowPad = `FP_PATH_W - `FP_MAN_W - 2; // Guard bits plus sticky

	fpFormatPkg::fpHalf a;
	fpFormatPkg::fpHalf b;
	logic aZero, bZero, aNan, bNan, aInf, bInf;
	logic signB;                         // b sign after the opcode
	logic [`FP_EXP_W+`FP_MAN_W-1:0] aMag, bMag;
	logic swap;
	fpFormatPkg::manPath mantA, mantB, mantBig, mantSmall, mantAligned;
	logic [`FP_EXP_W-1:0] expBig, expSmall, expDiff;
	logic signBig, signSmall;
	logic [2*pathW-1:0] shiftWide;       // Small mantissa over the shifted-out bits
	fpFormatPkg::stageWord stageNext;

	assign a = operands.a;
	assign b = operands.b;

	// Subnormals flush to zero
	assign aZero = (a.exponent == '0);
	assign bZero = (b.exponent == '0);
	assign aNan  = (&a.exponent) && (|a.fraction);
	assign bNan  = (&b.exponent) && (|b.fraction);
	assign aInf  = (&a.exponent) && !(|a.fraction);
	assign bInf  = (&b.exponent) && !(|b.fraction);
	assign signB = b.sign ^ (operands.op == streamPkg::opSub);

	assign aMag  = aZero ? '0 : {a.exponent, a.fraction};
	assign bMag  = bZero ? '0 : {b.exponent, b.fraction};
	assign swap  = (bMag > aMag); // Larger magnitude goes first

	assign mantA = aZero ? '0 : {2'b01, a.fraction, {lowPad{1'b0}}};
	assign mantB = bZero ? '0 : {2'b01, b.fraction, {lowPad{1'b0}}};

	assign mantBig   = swap ? mantB : mantA;
	assign mantSmall = swap ? mantA : mantB;
	assign expBig    = swap ? b.exponent : a.exponent;
	assign expSmall  = swap ? a.exponent : b.exponent;
	assign signBig   = swap ? signB : a.sign;
	assign signSmall = swap ? a.sign : signB;
	assign expDiff   = expBig - expSmall; // Never negative after the swap

	// Anything pushed past bit 0 ends up in sticky
	assign shiftWide   = {mantSmall, {pathW{1'b0}}} >> expDiff;
	assign mantAligned = {shiftWide[2*pathW-1:pathW+1],
		shiftWide[pathW] | (|shiftWide[pathW-1:0])};

	always_comb begin
		stageNext.sign     = signBig;
		stageNext.exponent = {2'b00, expBig};
		stageNext.tag      = operands.tag;
		if (signBig ^ signSmall) begin
			stageNext.mantissa = mantBig - mantAligned; // Effective subtract never borrows out
		end else begin
			stageNext.mantissa = mantBig + mantAligned;
		end
		stageNext.special     = fpFormatPkg::specNone;
		stageNext.specialSign = 1'b0;
		if (aNan || bNan) begin
			stageNext.special = fpFormatPkg::specNan;
		end else if (aInf && bInf && (a.sign != signB)) begin
			stageNext.special = fpFormatPkg::specNan; // inf - inf
		end else if (aInf || bInf) begin
			stageNext.special     = fpFormatPkg::specInf;
			stageNext.specialSign = aInf ? a.sign : signB;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
		end else begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		stage <= stageNext;
	end

endmodule

`default_nettype wire

/* hdl/fpNormalize.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpAdd_defines.svh"

// Stage 2: bring the hidden bit back to its place
module fpNormalize (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  inValid,
	input  fpFormatPkg::stageWord stageIn,
	output logic                  outValid,
	output fpFormatPkg::stageWord stageOut
);

	localparam int pathW = `FP_PATH_W;
	localparam int expW  = `FP_EXP_W + 2;
	localparam logic signed [expW-1:0] expOne = 1;

	logic [3:0]            lzCount;  // Zeros above the leading one
	fpFormatPkg::manPath   shifted;
	fpFormatPkg::stageWord stageNext;

	// Leading zeros from the hidden bit down, 15 at most
	function automatic logic [3:0] leadZeros(input fpFormatPkg::manPath m);
		logic [3:0] count;
		count = 4'd15;
		for (int i = 0; i < pathW - 1; i++) begin
			if (m[i]) count = 4'(pathW - 2 - i); // Highest set bit wins
		end
		return count;
	endfunction

	assign lzCount = leadZeros(stageIn.mantissa);

	normalizeShift shifter (
		.mantissaIn (stageIn.mantissa),
		.shift      (lzCount),
		.mantissaOut(shifted)
	);

	always_comb begin
		stageNext = stageIn;
		if (stageIn.mantissa[pathW-1]) begin
			// Carry out, one step right, lost bit folds into sticky
			stageNext.mantissa = {1'b0, stageIn.mantissa[pathW-1:2],
				stageIn.mantissa[1] | stageIn.mantissa[0]};
			stageNext.exponent = stageIn.exponent + expOne;
		end else begin
			stageNext.mantissa = shifted;
			stageNext.exponent = stageIn.exponent - $signed({{(expW-4){1'b0}}, lzCount});
		end
		if ((stageIn.mantissa == '0) && (stageIn.special == fpFormatPkg::specNone)) begin
			stageNext.special     = fpFormatPkg::specZero; // Exact cancellation
			stageNext.specialSign = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) outValid <= 1'b0;
		else       outValid <= inValid;
	end

	always_ff @(posedge clk) begin
		stageOut <= stageNext;
	end

endmodule

`default_nettype wire

/* hdl/fpRoundPack.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpAdd_defines.svh"

// Stage 3: round to nearest even, range check, pack
module fpRoundPack (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  inValid,
	input  fpFormatPkg::stageWord stageIn,
	output logic                  outValid,
	output streamPkg::fpResult    result
);

	localparam int pathW   = `FP_PATH_W;
	localparam int fracLsb = `FP_PATH_W - 2 - `FP_MAN_W; // Bit 5 of the path word
	localparam int expMax  = 2 * `FP_BIAS + 1;           // All-ones exponent
	localparam logic [`FP_WIDTH-1:0] canonicalNan = 'h7E00;

	fpFormatPkg::manPath          m;
	logic                         guardBit;
	logic                         stickyAll; // Everything below guard
	logic                         roundUp;
	logic [`FP_MAN_W+1:0]         rounded;   // Overflow | hidden | fraction
	logic signed [`FP_EXP_W+1:0]  expRounded;
	logic [`FP_MAN_W-1:0]         fracOut;
	fpFormatPkg::fpHalf           packedWord;

	assign m         = stageIn.mantissa;
	assign guardBit  = m[fracLsb-1];
	assign stickyAll = |m[fracLsb-2:0];
	assign roundUp   = guardBit && (stickyAll || m[fracLsb]); // Ties go to even

	assign rounded    = {1'b0, m[pathW-2:fracLsb]} + {{(`FP_MAN_W+1){1'b0}}, roundUp};
	assign expRounded = stageIn.exponent
		+ $signed({{(`FP_EXP_W+1){1'b0}}, rounded[`FP_MAN_W+1]});
	// Round carry only from all ones, fraction becomes zero
	assign fracOut = rounded[`FP_MAN_W+1] ? rounded[`FP_MAN_W:1] : rounded[`FP_MAN_W-1:0];

	always_comb begin
		if (expRounded >= expMax) begin
			packedWord = {stageIn.sign, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}}; // Overflow
		end else if (expRounded <= 0) begin
			packedWord = {stageIn.sign, {(`FP_WIDTH-1){1'b0}}}; // Flush to zero
		end else begin
			packedWord = {stageIn.sign, expRounded[`FP_EXP_W-1:0], fracOut};
		end
		case (stageIn.special)
			fpFormatPkg::specNan:  packedWord = canonicalNan;
			fpFormatPkg::specInf:
				packedWord = {stageIn.specialSign, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
			fpFormatPkg::specZero: packedWord = {stageIn.specialSign, {(`FP_WIDTH-1){1'b0}}};
			default:               packedWord = packedWord; // Computed value stands
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) outValid <= 1'b0;
		else       outValid <= inValid;
	end

	always_ff @(posedge clk) begin
		result.value <= packedWord;
		result.tag   <= stageIn.tag;
	end

endmodule

`default_nettype wire

/* hdl/fpAddSubTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpAdd_defines.svh"

// Credit-flow fp16 add/sub with three pipeline stages
module fpAddSubTop (
	input  logic               clk,
	input  logic               reset,
	input  logic               inValid,
	input  streamPkg::opPair   inData,
	output logic               inCredit,
	input  logic               outCreditReturn,
	output logic               outValid,
	output streamPkg::fpResult outData
);

	localparam int freeW   = $clog2(`OUT_DEPTH + 1);
	localparam int creditW = 8;

	streamPkg::opPair      headPair;
	streamPkg::fpResult    roundResult;
	logic                  inEmpty;
	logic                  outEmpty;
	logic [freeW-1:0]      outFree;
	logic [freeW-1:0]      inFlight;   // Items between pop and result push
	logic                  admit;
	logic                  alignValid, normValid, roundValid;
	fpFormatPkg::stageWord alignStage, normStage;
	logic [creditW-1:0]    outCredits; // Receiver slots granted and unused

	creditFifo #(.payloadType(streamPkg::opPair), .DEPTH(`IN_DEPTH)) inFifo (
		.clk      (clk),
		.reset    (reset),
		.push     (inValid),  // Sender holds a credit
		.pushData (inData),
		.pop      (admit),
		.popData  (headPair),
		.empty    (inEmpty),
		.freeCount()
	);

	// Reserve a result slot for every stage in flight
	assign inFlight = freeW'(alignValid) + freeW'(normValid) + freeW'(roundValid);
	assign admit    = !inEmpty && (outFree > inFlight);
	assign inCredit = admit; // Slot freed in the input fifo

	fpAlign align (
		.clk     (clk),
		.reset   (reset),
		.inValid (admit),
		.operands(headPair),
		.outValid(alignValid),
		.stage   (alignStage)
	);

	fpNormalize normalize (
		.clk     (clk),
		.reset   (reset),
		.inValid (alignValid),
		.stageIn (alignStage),
		.outValid(normValid),
		.stageOut(normStage)
	);

	fpRoundPack roundPack (
		.clk     (clk),
		.reset   (reset),
		.inValid (normValid),
		.stageIn (normStage),
		.outValid(roundValid),
		.result  (roundResult)
	);

	creditFifo #(.payloadType(streamPkg::fpResult), .DEPTH(`OUT_DEPTH)) outFifo (
		.clk      (clk),
		.reset    (reset),
		.push     (roundValid), // Always has room, see admit
		.pushData (roundResult),
		.pop      (outValid),
		.popData  (outData),
		.empty    (outEmpty),
		.freeCount(outFree)
	);

	// One beat per returned credit
	always_ff @(posedge clk) begin
		if (reset) begin
			outCredits <= '0;
		end else begin
			outCredits <= outCredits + creditW'(outCreditReturn) - creditW'(outValid);
		end
	end

	assign outValid = !outEmpty && (outCredits != '0);

endmodule

`default_nettype wire

/* dv/fpAddSubChecker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpAdd_defines.svh"

// Watches both credit channels and compares every result beat
module fpAddSubChecker #(
	parameter int numEntries = 1
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 inValid,
	input  logic                 inCredit,
	input  logic                 outCreditReturn,
	input  logic                 outValid,
	input  streamPkg::fpResult   outData,
	input  logic [`FP_WIDTH-1:0] expected [numEntries],
	output int                   beatCount,
	output int                   dataErrors,
	output int                   protocolErrors
);

	localparam int idxW = $clog2(numEntries);

	int   accepted;        // Requests written into the input fifo
	int   creditPulses;
	int   creditsReturned; // Slots granted by the receiver
	logic seenInput;

	always @(posedge clk) begin
		if (reset) begin
			accepted        = 0;
			creditPulses    = 0;
			creditsReturned = 0;
			seenInput       = 1'b0;
			beatCount       = 0;
			dataErrors      = 0;
			protocolErrors  = 0;
		end else begin
			// Nothing may move before the first request
			if (!seenInput && (inCredit || outValid)) begin
				protocolErrors++;
				$display("inCredit or outValid went high before any request was sent");
			end
			if (inCredit) begin
				creditPulses++;
				if (creditPulses > accepted) begin
					protocolErrors++;
					$display("inCredit pulse with no accepted request left to free");
				end
			end
			if (inValid) begin
				accepted++;
				seenInput = 1'b1;
				if (accepted - creditPulses > `IN_DEPTH) begin
					protocolErrors++;
					$display("More than %0d requests outstanding on the input side", `IN_DEPTH);
				end
			end
			if (outValid) begin
				if (beatCount >= creditsReturned) begin // Returns from earlier cycles only
					protocolErrors++;
					$display("Result beat %0d sent without a returned credit", beatCount);
				end
				if (beatCount >= numEntries) begin
					protocolErrors++;
					$display("Extra result beat after all %0d requests came back", numEntries);
				end else if (outData.tag !== `TAG_W'(beatCount)) begin
					dataErrors++; // Out of order or corrupted tag
					$display("Error: outData.tag = %h, expected %h", outData.tag,
						`TAG_W'(beatCount));
				end
				if ((int'(outData.tag) < numEntries) &&
					(outData.value !== expected[idxW'(outData.tag)])) begin
					dataErrors++;
					$display("Error: outData.value = %h, expected %h (tag %h)", outData.value,
						expected[idxW'(outData.tag)], outData.tag);
				end
				beatCount++;
			end
			if (outCreditReturn) creditsReturned++;
		end
	end

endmodule

`default_nettype wire

/* dv/fpAddSubTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpAdd_defines.svh"

module fpAddSubTb;

	localparam int numEntries = 36;
	localparam int idxW       = $clog2(numEntries);
	localparam int cycleLimit = 2000; // Bound on the whole exchange

	typedef struct packed {
		fpFormatPkg::fpHalf a;
		fpFormatPkg::fpHalf b;
		streamPkg::fpOp     op;
		fpFormatPkg::fpHalf result; // Expected bits
	} testVector;

	logic               clk;
	logic               reset;
	logic               inValid;
	streamPkg::opPair   inData;
	logic               inCredit;
	logic               outCreditReturn;
	logic               outValid;
	streamPkg::fpResult outData;

	testVector            vectors [numEntries];
	logic [`FP_WIDTH-1:0] expectedCol [numEntries];
	int                   fillIndex;
	int                   sent;        // Requests driven
	int                   granted;     // Output credits handed to the DUT
	int                   creditsBack; // inCredit pulses
	int                   cycles;
	int                   flowErrors;
	int                   beatCount;
	int                   dataErrors;
	int                   protocolErrors;
	logic [31:0]          rnd;

	fpAddSubTop uut (
		.clk            (clk),
		.reset          (reset),
		.inValid        (inValid),
		.inData         (inData),
		.inCredit       (inCredit),
		.outCreditReturn(outCreditReturn),
		.outValid       (outValid),
		.outData        (outData)
	);

	fpAddSubChecker #(.numEntries(numEntries)) resultCheck (
		.clk            (clk),
		.reset          (reset),
		.inValid        (inValid),
		.inCredit       (inCredit),
		.outCreditReturn(outCreditReturn),
		.outValid       (outValid),
		.outData        (outData),
		.expected       (expectedCol),
		.beatCount      (beatCount),
		.dataErrors     (dataErrors),
		.protocolErrors (protocolErrors)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic addEntry(input logic [15:0] a, input logic [15:0] b,
		input streamPkg::fpOp op, input logic [15:0] result);
		vectors[idxW'(fillIndex)]     = {a, b, op, result};
		expectedCol[idxW'(fillIndex)] = vectors[idxW'(fillIndex)].result;
		fillIndex++;
	endtask

	task automatic loadTable();
		addEntry(16'h3C00, 16'h4000, streamPkg::opAdd, 16'h4200); // 1 + 2
		addEntry(16'h4000, 16'h3800, streamPkg::opSub, 16'h3E00); // 2 - 0.5
		addEntry(16'h3E00, 16'h3E00, streamPkg::opAdd, 16'h4200); // Carry out
		addEntry(16'hBC00, 16'h3800, streamPkg::opAdd, 16'hB800);
		addEntry(16'h4248, 16'h3E00, streamPkg::opAdd, 16'h44A4); // 3.140625 + 1.5
		addEntry(16'h3C00, 16'h1000, streamPkg::opAdd, 16'h3C00); // Tie stays even
		addEntry(16'h3C01, 16'h1000, streamPkg::opAdd, 16'h3C02); // Odd LSB tie rounds up
		addEntry(16'h3C00, 16'h1001, streamPkg::opAdd, 16'h3C01); // Above half via sticky
		addEntry(16'h3C00, 16'h0C00, streamPkg::opSub, 16'h3C00); // Tie after borrow
		// (1 + 2^-s) - 1 leaves 2^-s after a shift of s
		for (int shiftBy = 1; shiftBy <= 10; shiftBy++) begin
			addEntry(16'h3C00 | (16'h1 << (10 - shiftBy)), 16'h3C00, streamPkg::opSub,
				16'((15 - shiftBy) << 10));
		end
		addEntry(16'h4200, 16'h3C00, streamPkg::opSub, 16'h4000); // Shift 0
		addEntry(16'h3C00, 16'h3BFF, streamPkg::opSub, 16'h1000); // Shift 11 leaves 2^-11
		addEntry(16'h4500, 16'h4500, streamPkg::opSub, 16'h0000); // x - x
		addEntry(16'hC500, 16'h4500, streamPkg::opAdd, 16'h0000);
		addEntry(16'h7C01, 16'h3C00, streamPkg::opAdd, 16'h7E00); // NaN in
		addEntry(16'h7C00, 16'h7C00, streamPkg::opSub, 16'h7E00); // inf - inf
		addEntry(16'hFC00, 16'h7C00, streamPkg::opAdd, 16'h7E00);
		addEntry(16'h7C00, 16'h7C00, streamPkg::opAdd, 16'h7C00);
		addEntry(16'h7C00, 16'h3C00, streamPkg::opAdd, 16'h7C00); // inf + finite
		addEntry(16'h3C00, 16'h7C00, streamPkg::opSub, 16'hFC00);
		addEntry(16'h0200, 16'h3C00, streamPkg::opAdd, 16'h3C00); // Subnormal reads as 0
		addEntry(16'h0001, 16'h0001, streamPkg::opAdd, 16'h0000);
		addEntry(16'h7BFF, 16'h7BFF, streamPkg::opAdd, 16'h7C00); // 65504 + 65504
		addEntry(16'hFBFF, 16'hFBFF, streamPkg::opAdd, 16'hFC00);
		addEntry(16'h7BFF, 16'h4C00, streamPkg::opAdd, 16'h7C00); // Rounding overflows
		addEntry(16'h0401, 16'h0400, streamPkg::opSub, 16'h0000); // 2^-24 flushes
		addEntry(16'h8401, 16'h0400, streamPkg::opAdd, 16'h8000); // Keeps its sign
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		if (reset) creditsBack <= 0;
		else if (inCredit) creditsBack <= creditsBack + 1;
	end

	initial begin
		reset           = 1'b1;
		inValid         = 1'b0;
		inData          = '0;
		outCreditReturn = 1'b0;
		fillIndex       = 0;
		sent            = 0;
		granted         = 0;
		flowErrors      = 0;
		rnd             = 32'h1aeb_588f;
		loadTable();
		if (fillIndex != numEntries) begin
			flowErrors++;
			$display("Table holds %0d entries instead of %0d", fillIndex, numEntries);
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// Idle with two credits granted and quiet outputs
		for (int i = 0; i < 8; i++) begin
			outCreditReturn = (i < 2);
			granted += (i < 2) ? 1 : 0;
			@(negedge clk);
		end
		outCreditReturn = 1'b0;
		cycles = 0;
		while ((beatCount < numEntries) && (cycles < cycleLimit)) begin
			@(negedge clk);
			cycles++;
			rnd = xorshift(rnd);
			if ((sent < numEntries) && (sent - creditsBack < `IN_DEPTH)
				&& (rnd[2:0] != 3'd0)) begin
				inValid     = 1'b1;
				inData.a    = vectors[idxW'(sent)].a;
				inData.b    = vectors[idxW'(sent)].b;
				inData.op   = vectors[idxW'(sent)].op;
				inData.tag  = `TAG_W'(sent); // Tag is the table index
				sent++;
			end else begin
				inValid = 1'b0;
			end
			// Sparse grants so the output fifo backs up
			outCreditReturn = (granted < numEntries) && (granted - beatCount < `OUT_DEPTH)
				&& (rnd[9:8] == 2'b00);
			if (outCreditReturn) granted++;
		end
		@(negedge clk);
		inValid         = 1'b0;
		outCreditReturn = 1'b0;
		if (beatCount < numEntries) begin
			flowErrors++;
			$display("Timed out with %0d of %0d results after %0d cycles", beatCount,
				numEntries, cycles);
		end
		repeat (10) @(negedge clk); // Let any stray beat show up
		if ((sent != numEntries) || (creditsBack != sent)) begin
			flowErrors++;
			$display("Sent %0d requests but saw %0d inCredit pulses", sent, creditsBack);
		end
		$display("Errors: data %0d, protocol %0d, flow %0d", dataErrors, protocolErrors,
			flowErrors);
		if ((dataErrors + protocolErrors + flowErrors) == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hdl
hdl/fpFormatPkg.sv
hdl/streamPkg.sv
hdl/creditFifo.sv
hdl/normalizeShift.sv
hdl/fpAlign.sv
hdl/fpNormalize.sv
hdl/fpRoundPack.sv
hdl/fpAddSubTop.sv
dv/fpAddSubChecker.sv
dv/fpAddSubTb.sv

/* Makefile */
TOP := fpAddSubTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary -sv -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
